// File: hdl/spi_bus_pkg.sv
/*
 * SPI bus definitions.
 * Word size, clock mode and prescaler types shared by the host side
 * and the shift engine.
 */
`default_nettype none

package spi_bus_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Sizes

    localparam int word_len = 8;    // Bits shifted per transfer.
    localparam int mode_w   = 2;    // CPOL and CPHA.
    localparam int presc_w  = 3;    // Power-of-two exponent of the SCK divider.

    ////////////////////////////////////////////////////////////////////////////
    // Types

    // One transfer word, as written by the host and as received from the slave.
    typedef logic [word_len-1:0] word_t;

    // SPI mode. Bit 1 is the clock polarity, a one makes SCK idle high.
    // Bit 0 is the clock phase. With a zero the slave samples on the first
    // edge of each bit, with a one on the second edge.
    typedef logic [mode_w-1:0] spi_mode_t;

    // Prescaler exponent. One SCK half period lasts 2^(presc+1) clock cycles,
    // so the slowest setting gives 256 cycles per half period.
    typedef logic [presc_w-1:0] presc_t;

endpackage : spi_bus_pkg

`default_nettype wire

// File: hdl/spi_ctrl_pkg.sv
/*
 * SPI master control definitions.
 * Engine state encoding and the widths of the internal counters.
 */
`default_nettype none

package spi_ctrl_pkg;

    // Shift engine states. Idle waits for a buffered word, shift runs a word.
    typedef enum logic {
        st_idle,
        st_shift
    } engine_state_t;

    localparam int half_cnt_w = 9;  // Holds a count of up to 256 cycles.
    localparam int edge_cnt_w = 5;  // Holds the edge index of one word.

    // Two SCK edges per bit.
    localparam int edges_per_word = 2 * spi_bus_pkg::word_len;

    typedef logic [half_cnt_w-1:0] half_cnt_t;  // Cycles within a half period.
    typedef logic [edge_cnt_w-1:0] edge_cnt_t;  // SCK edges within a word.

endpackage : spi_ctrl_pkg

`default_nettype wire

// File: hdl/spi_half_period_timer.sv
/*
 * SCK half-period timer.
 * Counts clock cycles while the engine runs and pulses half_done at the
 * end of every half period of 2^(presc+1) cycles.
 */
`timescale 1ns/1ns
`default_nettype none

module spi_half_period_timer (
    input  logic                wr,
    input  logic                rst,
    input  logic                run,
    input  spi_bus_pkg::presc_t presc,
    output logic                half_done
);
    import spi_ctrl_pkg::*;

    half_cnt_t cnt;     // Cycles elapsed in the current half period.
    half_cnt_t term;    // Last count of a half period.

    // Terminal count is 2^(presc+1) - 1, the widened exponent avoids a wrap at 7.
    assign term = (half_cnt_t'(1) << ({1'b0, presc} + 4'd1)) - half_cnt_t'(1);

    // Combinational so the engine sees the pulse in the last cycle itself.
    assign half_done = run && (cnt == term);

    always_ff @(posedge wr or posedge rst) begin
        if (rst) begin
            cnt <= '0;
        end else if (!run || half_done) begin
            cnt <= '0;  // Every word and every half period starts from zero.
        end else begin
            cnt <= cnt + half_cnt_t'(1);
        end
    end

    // The divider setting holds still for the whole word.
    a_presc_stable : assert property (
        @(posedge wr) disable iff (rst) (run && $past(run)) |-> $stable(presc)
    ) else $error("spi_half_period_timer: prescaler changed while running.");

endmodule : spi_half_period_timer

`default_nettype wire

// File: hdl/spi_master_top.sv
/*
 * Single-channel SPI master.
 * Transmit holding buffer, shift engine with its half-period timer and
 * receive register, all clocked by wr.
 */
`timescale 1ns/1ns
`default_nettype none

module spi_master_top (
    input  logic                   wr,
    input  logic                   rst,
    input  logic                   tx_write,
    input  spi_bus_pkg::word_t     tx_data,
    input  spi_bus_pkg::spi_mode_t mode,
    input  logic                   lsb_first,
    input  spi_bus_pkg::presc_t    presc,
    input  logic                   send_err_clear,
    input  logic                   rd,
    input  logic                   miso,
    output logic                   tx_empty,
    output logic                   send_err,
    output spi_bus_pkg::word_t     rx_data,
    output logic                   char_received,
    output logic                   ss,
    output logic                   sck,
    output logic                   mosi
);
    import spi_bus_pkg::*;

    logic   run;        // Engine is shifting a word.
    logic   half_done;  // End of an SCK half period.
    presc_t presc_q;    // Prescaler of the word in flight.
    word_t  rx_word;
    logic   rx_strobe;

    spi_xfer_if xfer ();

    assign tx_empty = ~xfer.pending;

    spi_tx_holding u_tx_holding (
        .wr             (wr),
        .rst            (rst),
        .tx_write       (tx_write),
        .tx_data        (tx_data),
        .mode           (mode),
        .lsb_first      (lsb_first),
        .presc          (presc),
        .send_err_clear (send_err_clear),
        .send_err       (send_err),
        .xfer           (xfer.src)
    );

    spi_half_period_timer u_timer (
        .wr        (wr),
        .rst       (rst),
        .run       (run),
        .presc     (presc_q),
        .half_done (half_done)
    );

    spi_shift_engine u_engine (
        .wr        (wr),
        .rst       (rst),
        .xfer      (xfer.dst),
        .half_done (half_done),
        .run       (run),
        .presc_q   (presc_q),
        .miso      (miso),
        .ss        (ss),
        .sck       (sck),
        .mosi      (mosi),
        .rx_word   (rx_word),
        .rx_strobe (rx_strobe)
    );

    spi_rx_holding u_rx_holding (
        .wr            (wr),
        .rst           (rst),
        .rx_word       (rx_word),
        .rx_strobe     (rx_strobe),
        .rd            (rd),
        .rx_data       (rx_data),
        .char_received (char_received)
    );

endmodule : spi_master_top

`default_nettype wire

// File: hdl/spi_rx_holding.sv
/*
 * Receive holding register.
 * Keeps the last word from the shift engine and flags it until the host
 * reads it.
 */
`timescale 1ns/1ns
`default_nettype none

module spi_rx_holding (
    input  logic               wr,
    input  logic               rst,
    input  spi_bus_pkg::word_t rx_word,
    input  logic               rx_strobe,
    input  logic               rd,
    output spi_bus_pkg::word_t rx_data,
    output logic               char_received
);

    // Flag control. A new word beats a read in the same cycle.
    always_ff @(posedge wr or posedge rst) begin
        if (rst) begin
            char_received <= 1'b0;
        end else if (rx_strobe) begin
            char_received <= 1'b1;
        end else if (rd) begin
            char_received <= 1'b0;  // Host has read the word.
        end
    end

    // Overwrites an unread word, the flag simply stays set.
    always_ff @(posedge wr) begin
        if (rx_strobe)
            rx_data <= rx_word;
    end

    // A word takes at least 16 half periods, so strobes never touch.
    a_strobe_single : assert property (
        @(posedge wr) disable iff (rst) rx_strobe |=> !rx_strobe
    ) else $error("spi_rx_holding: receive strobe held for two cycles.");

endmodule : spi_rx_holding

`default_nettype wire

// File: hdl/spi_shift_engine.sv
/*
 * SPI shift engine.
 * Takes a buffered word, drives SS, SCK and MOSI for all four modes, shifts
 * MISO in and strobes the received word at the end of each transfer.
 */
`timescale 1ns/1ns
`default_nettype none

module spi_shift_engine (
    input  logic                wr,
    input  logic                rst,
    spi_xfer_if.dst             xfer,
    input  logic                half_done,
    output logic                run,
    output spi_bus_pkg::presc_t presc_q,
    input  logic                miso,
    output logic                ss,
    output logic                sck,
    output logic                mosi,
    output spi_bus_pkg::word_t  rx_word,
    output logic                rx_strobe
);
    import spi_bus_pkg::*;
    import spi_ctrl_pkg::*;

    engine_state_t state;
    edge_cnt_t     edge_cnt;    // Index of the next SCK edge in the word.
    logic          sck_q;       // Internal clock phase, zero at idle.
    spi_mode_t     mode_q;      // Mode of the word in flight.
    logic          lsb_q;       // Bit order of the word in flight.
    word_t         tx_sreg;     // Bits still to go out.
    word_t         rx_sreg;     // Bits collected from MISO.
    logic          mosi_q;      // Registered data bit.
    logic          last_edge;
    logic          sample_edge;

    // Bit that leaves first for the given order.
    function automatic logic head_bit(word_t w, logic lsb);
        return lsb ? w[0] : w[word_len-1];
    endfunction

    // Drops the head bit and fills the far end with ones.
    function automatic word_t shift_out(word_t w, logic lsb);
        return lsb ? {1'b1, w[word_len-1:1]} : {w[word_len-2:0], 1'b1};
    endfunction

    assign run       = (state == st_shift);
    assign xfer.take = (state == st_idle) && xfer.pending;   // Take in one cycle.

    // Even edges open a bit, odd edges close it. The slave samples on the
    // edge whose parity equals CPHA and the master moves data on the other.
    assign sample_edge = half_done && (edge_cnt[0] == mode_q[0]);
    assign last_edge   = half_done && (edge_cnt == edge_cnt_t'(edges_per_word - 1));

    ////////////////////////////////////////////////////////////////////////////
    // Transfer control

    always_ff @(posedge wr or posedge rst) begin
        if (rst) begin
            state     <= st_idle;
            edge_cnt  <= '0;
            sck_q     <= 1'b0;
            ss        <= 1'b1;      // Slave deselected.
            mode_q    <= '0;        // Mode 0 keeps SCK low out of reset.
            rx_strobe <= 1'b0;
        end else begin
            rx_strobe <= 1'b0;
            case (state)
                st_idle: begin
                    if (xfer.pending) begin
                        state    <= st_shift;
                        ss       <= 1'b0;           // Stays low for back-to-back words.
                        mode_q   <= xfer.mode;
                        edge_cnt <= '0;
                        sck_q    <= 1'b0;
                    end else begin
                        ss <= 1'b1;                 // Nothing queued, release the slave.
                    end
                end
                st_shift: begin
                    if (half_done) begin
                        sck_q <= ~sck_q;            // One SCK edge per half period.
                        if (last_edge) begin
                            edge_cnt  <= '0;
                            state     <= st_idle;   // SCK is back at idle here.
                            rx_strobe <= 1'b1;      // Received word is complete.
                        end else begin
                            edge_cnt <= edge_cnt + edge_cnt_t'(1);
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Data path

    always_ff @(posedge wr) begin
        if (xfer.take) begin
            lsb_q   <= xfer.lsb_first;
            presc_q <= xfer.presc;
            if (!xfer.mode[0]) begin
                // Phase 0 needs the first bit on the line before the first edge.
                mosi_q  <= head_bit(xfer.word, xfer.lsb_first);
                tx_sreg <= shift_out(xfer.word, xfer.lsb_first);
            end else begin
                mosi_q  <= 1'b1;    // Line stays high until the first edge.
                tx_sreg <= xfer.word;
            end
        end else if (run && half_done) begin
            if (sample_edge) begin
                // MSB first fills from the bottom, LSB first from the top.
                if (lsb_q)
                    rx_sreg <= {miso, rx_sreg[word_len-1:1]};
                else
                    rx_sreg <= {rx_sreg[word_len-2:0], miso};
            end else begin
                mosi_q  <= head_bit(tx_sreg, lsb_q);    // Fill bits after the last.
                tx_sreg <= shift_out(tx_sreg, lsb_q);
            end
        end
    end

    assign sck     = sck_q ^ mode_q[1];     // Polarity 1 inverts the phase.
    assign mosi    = ss ? 1'b1 : mosi_q;    // Idle high while deselected.
    assign rx_word = rx_sreg;               // Stable until the next sample edge.

    // The edge count per word is even, so a deselected bus never shows a
    // stray SCK level.
    a_sck_idle : assert property (
        @(posedge wr) disable iff (rst) ss |-> (sck == mode_q[1])
    ) else $error("spi_shift_engine: SCK off its idle level while SS is high.");

endmodule : spi_shift_engine

`default_nettype wire

// File: hdl/spi_tx_holding.sv
/*
 * Transmit holding buffer.
 * Captures one word with its mode, bit order and prescaler on a host write
 * and keeps a sticky error flag for writes that hit a full buffer.
 */
`timescale 1ns/1ns
`default_nettype none

module spi_tx_holding (
    input  logic                   wr,
    input  logic                   rst,
    input  logic                   tx_write,
    input  spi_bus_pkg::word_t     tx_data,
    input  spi_bus_pkg::spi_mode_t mode,
    input  logic                   lsb_first,
    input  spi_bus_pkg::presc_t    presc,
    input  logic                   send_err_clear,
    output logic                   send_err,
    spi_xfer_if.src                xfer
);

    logic accept;   // Write that lands in an empty buffer.

    assign accept = tx_write && !xfer.pending;

    ////////////////////////////////////////////////////////////////////////////
    // Occupancy and error flag

    always_ff @(posedge wr or posedge rst) begin
        if (rst) begin
            xfer.pending <= 1'b0;   // Buffer starts empty.
            send_err     <= 1'b0;
        end else begin
            if (accept)
                xfer.pending <= 1'b1;
            else if (xfer.take)
                xfer.pending <= 1'b0;   // Engine has copied the word.

            // The clear request wins over a colliding write.
            if (send_err_clear)
                send_err <= 1'b0;
            else if (tx_write && xfer.pending)
                send_err <= 1'b1;   // The word is dropped and flagged.
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Word and settings

    // Only an accepted write loads, so the contents stay put while pending.
    always_ff @(posedge wr) begin
        if (accept) begin
            xfer.word      <= tx_data;
            xfer.mode      <= mode;
            xfer.lsb_first <= lsb_first;
            xfer.presc     <= presc;
        end
    end

    // The engine may only consume a word that is actually buffered.
    a_take_needs_pending : assert property (
        @(posedge wr) disable iff (rst) xfer.take |-> xfer.pending
    ) else $error("spi_tx_holding: take seen with an empty buffer.");

endmodule : spi_tx_holding

`default_nettype wire

// File: hdl/spi_xfer_if.sv
/*
 * Transfer hand-off between the transmit holding buffer and the shift engine.
 * Carries one pending word with the settings that were captured with it.
 */
`timescale 1ns/1ns
`default_nettype none

interface spi_xfer_if;

    logic                   pending;    // High while the buffer holds a word.
    spi_bus_pkg::word_t     word;       // Word waiting to be shifted.
    spi_bus_pkg::spi_mode_t mode;       // Mode captured with the word.
    logic                   lsb_first;  // Bit order captured with the word.
    spi_bus_pkg::presc_t    presc;      // Prescaler captured with the word.
    logic                   take;       // One-cycle pulse, the engine consumes it.

    // The buffer side. Word and settings hold still while pending is high.
    modport src (
        output pending,
        output word,
        output mode,
        output lsb_first,
        output presc,
        input  take
    );

    // The engine side. Pending drops on the edge after take.
    modport dst (
        input  pending,
        input  word,
        input  mode,
        input  lsb_first,
        input  presc,
        output take
    );

endinterface : spi_xfer_if

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build the SPI master testbench with Verilator and run it.
# The exit status follows the pass message in the simulation output.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module spi_master_tb -f sources.f -o spi_master_sim \
    && ./obj_dir/spi_master_sim | tee /dev/stderr | grep -qx "TEST PASS" \
    && echo "Simulation passed." \
    || { echo "Simulation failed."; exit 1; }

// File: sources.f
hdl/spi_bus_pkg.sv
hdl/spi_ctrl_pkg.sv
hdl/spi_xfer_if.sv
hdl/spi_tx_holding.sv
hdl/spi_half_period_timer.sv
hdl/spi_shift_engine.sv
hdl/spi_rx_holding.sv
hdl/spi_master_top.sv
tb/spi_master_tb.sv

// File: tb/spi_master_tb.sv
/*
 * Testbench for the SPI master.
 * A clocked slave model answers every word and records MOSI, while the
 * stimulus walks all modes, bit orders, back-to-back words and the send error.
 */
`timescale 1ns/1ns
`default_nettype none

module spi_master_tb;
    import spi_bus_pkg::*;

    localparam int wait_limit = 4000;   // Cycles allowed for any single wait.

    logic wr, rst, tx_write, lsb_first, send_err_clear, rd, miso;
    word_t tx_data, rx_data;
    spi_mode_t mode;
    presc_t presc;
    logic tx_empty, send_err, char_received, ss, sck, mosi;

    int errors = 0;
    logic timed_out = 1'b0;
    spi_mode_t cur_mode = '0;   // Settings the slave follows.
    logic cur_lsb = 1'b0;
    presc_t cur_presc = '0;
    logic idle_lvl = 1'b0;      // SCK level expected while SS is high.
    int ss_rises = 0;
    word_t mosi_words[$];       // Words seen by the slave.
    word_t reply_words[$];      // Words the slave sent back.

    spi_master_top dut0 (.*);

    initial begin
        wr = 1'b0;
        forever #2 wr = ~wr;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers

    // Bit k of a word in transmission order.
    function automatic logic order_bit(word_t w, int k, logic lsb);
        return lsb ? w[k] : w[word_len-1-k];
    endfunction

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic report_timeout(string what);
        $display("Timeout while waiting for %s.", what);
        timed_out = 1'b1;
        forever @(posedge wr);  // The watchdog ends the run.
    endtask

    task automatic print_counts();
        $display("Run finished with %0d errors and %0d timeouts.", errors, timed_out);
    endtask

    task automatic write_word(word_t w, spi_mode_t m, logic lsb, presc_t p);
        @(posedge wr);
        tx_write  <= 1'b1;
        tx_data   <= w;
        mode      <= m;
        lsb_first <= lsb;
        presc     <= p;
        @(posedge wr);
        tx_write  <= 1'b0;
    endtask

    task automatic wait_received();
        int n;
        n = 0;
        while (!char_received) begin
            if (n == wait_limit) report_timeout("char_received");
            n++;
            @(posedge wr);
        end
        @(posedge wr);  // Lets the slave log the finished word.
    endtask

    task automatic wait_tx_empty();
        int n;
        n = 0;
        @(posedge wr);  // The write has landed in the buffer by now.
        while (!tx_empty) begin
            if (n == wait_limit) report_timeout("tx_empty");
            n++;
            @(posedge wr);
        end
    endtask

    task automatic wait_words(int count);
        int n;
        n = 0;
        while (mosi_words.size() < count) begin
            if (n == wait_limit) report_timeout("words at the slave");
            n++;
            @(posedge wr);
        end
    endtask

    task automatic read_and_clear();
        @(posedge wr);
        rd <= 1'b1;
        @(posedge wr);
        rd <= 1'b0;
        @(posedge wr);
        @(posedge wr);
        check_value("char_received", char_received, 0);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Slave model, clocked by wr so every sampled pin has settled.

    int e = 0;          // Index of the next SCK edge in the word.
    int since_edge = 0; // Cycles since the last SCK edge.
    logic prev_sck = 1'b0;
    logic prev_ss = 1'b1;
    word_t cur_reply = '0;
    word_t got_word = '0;

    task automatic new_reply();
        cur_reply = word_t'($urandom);
        if (!cur_mode[0]) miso <= order_bit(cur_reply, 0, cur_lsb);  // Phase 0 leads.
    endtask

    always @(posedge wr) begin
        if (!rst) begin
            since_edge++;
            if (prev_ss && !ss) begin
                e = 0;
                got_word = '0;
                prev_sck = sck;     // Polarity may jump with the new mode.
                idle_lvl = cur_mode[1];
                new_reply();
            end
            if (!prev_ss && ss) ss_rises++;
            if (!ss && sck != prev_sck) begin
                if (e > 0)
                    check_value("sck half period", since_edge, 2 << cur_presc);
                since_edge = 0;
                if ((e % 2) == cur_mode[0]) begin
                    got_word[cur_lsb ? e/2 : word_len-1-e/2] = mosi;   // Sample edge.
                end else if ((cur_mode[0] ? e/2 : (e+1)/2) < word_len) begin
                    miso <= order_bit(cur_reply, cur_mode[0] ? e/2 : (e+1)/2, cur_lsb);
                end
                if (e == 2*word_len-1) begin
                    mosi_words.push_back(got_word);
                    reply_words.push_back(cur_reply);
                    e = 0;
                    got_word = '0;
                    new_reply();
                end else begin
                    e++;
                end
            end
            prev_sck = sck;
            prev_ss  = ss;
        end
    end

    // A deselected bus keeps SCK at the polarity of the last word.
    a_sck_idle : assert property (@(posedge wr) disable iff (rst) ss |-> sck == idle_lvl)
        else begin
            errors++;
            $display("Error at %0t ns: sck is %b, expected %b", $time, sck, idle_lvl);
        end

    always @(posedge wr) begin
        if (timed_out) begin
            print_counts();
            $display("TEST FAIL");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus

    initial begin
        word_t w1, w2;
        void'($urandom(32'h7d26_17dd));
        rst = 1'b1;
        tx_write = 1'b0;
        tx_data = '0;
        mode = '0;
        lsb_first = 1'b0;
        presc = '0;
        send_err_clear = 1'b0;
        rd = 1'b0;
        miso = 1'b1;
        repeat (8) @(posedge wr);
        rst <= 1'b0;
        @(posedge wr);
        @(posedge wr);
        check_value("ss", ss, 1);
        check_value("sck", sck, 0);
        check_value("mosi", mosi, 1);
        check_value("tx_empty", tx_empty, 1);
        check_value("send_err", send_err, 0);
        check_value("char_received", char_received, 0);

        // Every mode with both bit orders, one word each.
        for (int m = 0; m < 4; m++) begin
            for (int l = 0; l < 2; l++) begin
                w1 = word_t'($urandom);
                cur_mode = spi_mode_t'(m);
                cur_lsb = l[0];
                cur_presc = presc_t'($urandom % 4);
                write_word(w1, cur_mode, cur_lsb, cur_presc);
                wait_received();
                wait_words(1);
                check_value("mosi word", mosi_words.pop_front(), w1);
                check_value("rx_data", rx_data, reply_words.pop_front());
                read_and_clear();
            end
        end

        // Back-to-back words, then a third write into the full buffer.
        for (int k = 0; k < 2; k++) begin
            w1 = word_t'($urandom);
            w2 = word_t'($urandom);
            cur_mode = spi_mode_t'($urandom % 4);
            cur_lsb = 1'($urandom);
            cur_presc = presc_t'($urandom % 4);
            ss_rises = 0;
            write_word(w1, cur_mode, cur_lsb, cur_presc);
            wait_tx_empty();
            @(posedge wr);
            write_word(w2, cur_mode, cur_lsb, cur_presc);
            if (k == 1) begin
                @(posedge wr);
                check_value("tx_empty", tx_empty, 0);
                write_word(~w2, cur_mode, cur_lsb, cur_presc);    // Must be dropped.
                @(posedge wr);
                check_value("send_err", send_err, 1);
                send_err_clear <= 1'b1;
                @(posedge wr);
                send_err_clear <= 1'b0;
                @(posedge wr);
                check_value("send_err", send_err, 0);
            end
            wait_words(2);
            wait_received();
            check_value("first mosi word", mosi_words.pop_front(), w1);
            check_value("second mosi word", mosi_words.pop_front(), w2);
            void'(reply_words.pop_front());
            check_value("rx_data", rx_data, reply_words.pop_front());
            read_and_clear();
            // SS rises once, after the second word.
            check_value("ss rises over both words", ss_rises, 1);
            repeat (600) @(posedge wr);
            check_value("extra words at the slave", mosi_words.size(), 0);
        end

        print_counts();
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule : spi_master_tb

`default_nettype wire
